// ==== common/load_unit_pkg.sv ====
package load_unit_pkg;

    // buffer geometry.
    localparam int LD_DEPTH = 4;

    // datapath widths.
    localparam int XLEN = 32;
    localparam int DATA_W = 64;
    localparam int TAG_W = 6;
    localparam int BR_W = 4;

    // data memory, in 64-bit blocks.
    localparam int MEM_BLOCKS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_BLOCKS);
    localparam int MEM_LATENCY = 3;
    localparam int BLOCK_OFS_W = 3; // byte offset inside a block.

    // funct3[1:0] size codes.
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;
    localparam logic [1:0] SIZE_DOUBLE = 2'd3;

    // branch resolution tasks.
    localparam logic [1:0] BR_NONE = 2'd0;
    localparam logic [1:0] BR_SQUASH = 2'd1;
    localparam logic [1:0] BR_CLEAR = 2'd2;

    // load entry states.
    localparam logic [1:0] ST_EMPTY = 2'd0;
    localparam logic [1:0] ST_READY = 2'd1;   // waiting for a memory slot.
    localparam logic [1:0] ST_WAITING = 2'd2; // read in flight.
    localparam logic [1:0] ST_DONE = 2'd3;

    // one memory block, seen at every load size.
    typedef union packed {
        logic [7:0][7:0] bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
        logic [63:0] dbl;
    } mem_block_t;

endpackage

// ==== load_buffer/load_align.sv ====
module load_align (
    input  load_unit_pkg::mem_block_t        block,
    input  logic [2:0]                       offset,
    input  logic [2:0]                       funct3,
    output logic [load_unit_pkg::DATA_W-1:0] data
);
    import load_unit_pkg::*;

    logic [7:0] byte_lane;
    logic [15:0] half_lane;
    logic [31:0] word_lane;
    logic sign_ext;

    assign byte_lane = block.bytes[offset];
    assign half_lane = block.halves[offset[2:1]];
    assign word_lane = block.words[offset[2]];

    // lb/lh/lw sign extend, lbu/lhu/lwu do not.
    assign sign_ext = ~funct3[2];

    always_comb begin
        case (funct3[1:0])
            SIZE_BYTE: begin
                data = {{(DATA_W-8){sign_ext & byte_lane[7]}}, byte_lane};
            end
            SIZE_HALF: begin
                data = {{(DATA_W-16){sign_ext & half_lane[15]}}, half_lane};
            end
            SIZE_WORD: begin
                data = {{(DATA_W-32){sign_ext & word_lane[31]}}, word_lane};
            end
            default: begin
                data = block.dbl; // full double, nothing to extend.
            end
        endcase
    end

endmodule

// ==== load_buffer/load_buffer.sv ====
module load_buffer (
    input  logic                                                         clock,
    input  logic                                                         reset,
    input  logic                                                         issue_en,
    input  logic [load_unit_pkg::XLEN-1:0]                               issue_base,
    input  logic [load_unit_pkg::XLEN-1:0]                               issue_offset,
    input  logic [2:0]                                                   issue_funct3,
    input  logic [load_unit_pkg::TAG_W-1:0]                              issue_dest,
    input  logic [load_unit_pkg::BR_W-1:0]                               issue_br_mask,
    input  logic [1:0]                                                   br_task,
    input  logic [load_unit_pkg::BR_W-1:0]                               br_id,
    input  logic                                                         store_en,
    input  logic [load_unit_pkg::LD_DEPTH-1:0]                           cdb_stall,
    output logic                                                         full,
    output logic                                                         load_req,
    output logic [load_unit_pkg::XLEN-1:0]                               load_addr,
    input  logic                                                         resp_valid,
    input  logic [load_unit_pkg::XLEN-1:0]                               resp_addr,
    input  load_unit_pkg::mem_block_t                                    resp_block,
    output logic [load_unit_pkg::LD_DEPTH-1:0]                           result_valid,
    output logic [load_unit_pkg::LD_DEPTH-1:0][load_unit_pkg::TAG_W-1:0]  result_dest,
    output logic [load_unit_pkg::LD_DEPTH-1:0][load_unit_pkg::DATA_W-1:0] result_data
);
    import load_unit_pkg::*;

    // per entry state and payload.
    logic [LD_DEPTH-1:0][1:0] state;
    logic [LD_DEPTH-1:0][1:0] next_state;
    logic [LD_DEPTH-1:0][XLEN-1:0] addr;
    logic [LD_DEPTH-1:0][TAG_W-1:0] dest;
    logic [LD_DEPTH-1:0][2:0] funct3;
    logic [LD_DEPTH-1:0][BR_W-1:0] mask;
    logic [LD_DEPTH-1:0][DATA_W-1:0] result;
    logic [LD_DEPTH-1:0][DATA_W-1:0] aligned;

    logic [XLEN-1:0] eff_addr;
    logic [LD_DEPTH-1:0] free;
    logic [LD_DEPTH-1:0] ready;
    logic [LD_DEPTH-1:0] waiting;
    logic [LD_DEPTH-1:0] br_hit;
    logic [LD_DEPTH-1:0] squash;
    logic [LD_DEPTH-1:0] capture;
    logic [LD_DEPTH-1:0] accept;
    logic [LD_DEPTH-1:0] alloc_gnt;
    logic [LD_DEPTH-1:0] issue_req;
    logic [LD_DEPTH-1:0] issue_gnt;
    logic [LD_DEPTH-1:0] next_busy;
    logic [BR_W-1:0] new_mask;
    logic alloc_any;
    logic alloc_en;
    logic br_squash;
    logic br_clear;
    logic new_squashed;

    assign eff_addr = issue_base + issue_offset;

    assign br_squash = (br_task == BR_SQUASH);
    assign br_clear = (br_task == BR_CLEAR);

    // an incoming load can already be under the resolving branch.
    assign new_squashed = br_squash && ((issue_br_mask & br_id) != '0);
    assign new_mask = br_clear ? (issue_br_mask & ~br_id) : issue_br_mask;

    always_comb begin
        for (int i = 0; i < LD_DEPTH; i++) begin
            free[i] = (state[i] == ST_EMPTY);
            ready[i] = (state[i] == ST_READY);
            waiting[i] = (state[i] == ST_WAITING);
            br_hit[i] = !free[i] && ((mask[i] & br_id) != '0);
            squash[i] = br_hit[i] && br_squash;
            capture[i] = resp_valid && waiting[i]
                && (resp_addr[XLEN-1:BLOCK_OFS_W] == addr[i][XLEN-1:BLOCK_OFS_W]);
            result_valid[i] = (state[i] == ST_DONE);
        end
    end

    assign accept = result_valid & ~cdb_stall;
    assign result_dest = dest;
    assign result_data = result;

    priority_select #(
        .WIDTH(LD_DEPTH)
    ) allocator (
        .req(free),
        .gnt(alloc_gnt),
        .any(alloc_any)
    );

    assign alloc_en = issue_en && alloc_any;

    // stores own the memory port, and a dying entry never asks.
    assign issue_req = ready & ~squash & {LD_DEPTH{~store_en}};

    priority_select #(
        .WIDTH(LD_DEPTH)
    ) issuer (
        .req(issue_req),
        .gnt(issue_gnt),
        .any(load_req)
    );

    always_comb begin
        load_addr = '0;
        for (int i = 0; i < LD_DEPTH; i++) begin
            if (issue_gnt[i]) begin
                load_addr = {addr[i][XLEN-1:BLOCK_OFS_W], {BLOCK_OFS_W{1'b0}}};
            end
        end
    end

    for (genvar i = 0; i < LD_DEPTH; i++) begin : g_align
        load_align align_i (
            .block(resp_block),
            .offset(addr[i][BLOCK_OFS_W-1:0]),
            .funct3(funct3[i]),
            .data(aligned[i])
        );
    end

    always_comb begin
        next_state = state;
        for (int i = 0; i < LD_DEPTH; i++) begin
            if (accept[i]) begin
                next_state[i] = ST_EMPTY;
            end
            if (alloc_en && alloc_gnt[i] && !new_squashed) begin
                // tag zero has nothing to write back, skip memory.
                next_state[i] = (issue_dest == '0) ? ST_DONE : ST_READY;
            end
            if (issue_gnt[i]) begin
                next_state[i] = ST_WAITING;
            end
            if (capture[i]) begin
                next_state[i] = ST_DONE;
            end
            if (squash[i]) begin
                next_state[i] = ST_EMPTY; // late response finds nobody waiting.
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LD_DEPTH; i++) begin
            next_busy[i] = (next_state[i] != ST_EMPTY);
        end
    end

    assign full = &next_busy;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= '0;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < LD_DEPTH; i++) begin
            if (alloc_en && alloc_gnt[i]) begin
                addr[i] <= eff_addr;
                dest[i] <= issue_dest;
                funct3[i] <= issue_funct3;
                mask[i] <= new_mask;
                result[i] <= '0;
            end else begin
                if (br_clear && br_hit[i]) begin
                    mask[i] <= mask[i] & ~br_id;
                end
                if (capture[i]) begin
                    result[i] <= aligned[i];
                end
            end
        end
    end

endmodule

// ==== load_unit.f ====
common/load_unit_pkg.sv
source/priority_select.sv
load_buffer/load_align.sv
load_buffer/load_buffer.sv
source/data_memory.sv
source/load_unit_top.sv
verif/load_unit_asserts.sv
verif/load_unit_tb.sv

// ==== source/data_memory.sv ====
module data_memory (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            store_en,
    input  logic [load_unit_pkg::XLEN-1:0]  store_addr,
    input  load_unit_pkg::mem_block_t       store_data,
    input  logic                            load_req,
    input  logic [load_unit_pkg::XLEN-1:0]  load_addr,
    output logic                            resp_valid,
    output logic [load_unit_pkg::XLEN-1:0]  resp_addr,
    output load_unit_pkg::mem_block_t       resp_block
);
    import load_unit_pkg::*;

    mem_block_t mem [MEM_BLOCKS];

    logic [MEM_LATENCY-1:0] pipe_valid;
    logic [XLEN-1:0] pipe_addr [MEM_LATENCY];
    mem_block_t pipe_block [MEM_LATENCY];
    logic [MEM_IDX_W-1:0] store_idx;
    logic [MEM_IDX_W-1:0] load_idx;

    assign store_idx = store_addr[BLOCK_OFS_W +: MEM_IDX_W];
    assign load_idx = load_addr[BLOCK_OFS_W +: MEM_IDX_W];

    // whole block stores only.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int b = 0; b < MEM_BLOCKS; b++) begin
                mem[b] <= '0;
            end
        end else if (store_en) begin
            mem[store_idx] <= store_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], load_req};
        end
    end

    // array read in the first stage, then shifted out.
    always_ff @(posedge clock) begin
        pipe_addr[0] <= load_addr;
        pipe_block[0] <= mem[load_idx];
        for (int s = 1; s < MEM_LATENCY; s++) begin
            pipe_addr[s] <= pipe_addr[s-1];
            pipe_block[s] <= pipe_block[s-1];
        end
    end

    assign resp_valid = pipe_valid[MEM_LATENCY-1];
    assign resp_addr = pipe_addr[MEM_LATENCY-1];
    assign resp_block = pipe_block[MEM_LATENCY-1];

endmodule

// ==== source/load_unit_top.sv ====
module load_unit_top (
    input  logic                                                         clock,
    input  logic                                                         reset,
    input  logic                                                         issue_en,
    input  logic [load_unit_pkg::XLEN-1:0]                               issue_base,
    input  logic [load_unit_pkg::XLEN-1:0]                               issue_offset,
    input  logic [2:0]                                                   issue_funct3,
    input  logic [load_unit_pkg::TAG_W-1:0]                              issue_dest,
    input  logic [load_unit_pkg::BR_W-1:0]                               issue_br_mask,
    input  logic [1:0]                                                   br_task,
    input  logic [load_unit_pkg::BR_W-1:0]                               br_id,
    input  logic                                                         store_en,
    input  logic [load_unit_pkg::XLEN-1:0]                               store_addr,
    input  load_unit_pkg::mem_block_t                                    store_data,
    input  logic [load_unit_pkg::LD_DEPTH-1:0]                           cdb_stall,
    output logic                                                         full,
    output logic [load_unit_pkg::LD_DEPTH-1:0]                           result_valid,
    output logic [load_unit_pkg::LD_DEPTH-1:0][load_unit_pkg::TAG_W-1:0]  result_dest,
    output logic [load_unit_pkg::LD_DEPTH-1:0][load_unit_pkg::DATA_W-1:0] result_data
);
    import load_unit_pkg::*;

    logic load_req;
    logic [XLEN-1:0] load_addr;
    logic resp_valid;
    logic [XLEN-1:0] resp_addr;
    mem_block_t resp_block;

    load_buffer load_buffer_i (
        .clock(clock),
        .reset(reset),
        .issue_en(issue_en),
        .issue_base(issue_base),
        .issue_offset(issue_offset),
        .issue_funct3(issue_funct3),
        .issue_dest(issue_dest),
        .issue_br_mask(issue_br_mask),
        .br_task(br_task),
        .br_id(br_id),
        .store_en(store_en), // holds off load issue.
        .cdb_stall(cdb_stall),
        .full(full),
        .load_req(load_req),
        .load_addr(load_addr),
        .resp_valid(resp_valid),
        .resp_addr(resp_addr),
        .resp_block(resp_block),
        .result_valid(result_valid),
        .result_dest(result_dest),
        .result_data(result_data)
    );

    data_memory data_memory_i (
        .clock(clock),
        .reset(reset),
        .store_en(store_en),
        .store_addr(store_addr),
        .store_data(store_data),
        .load_req(load_req),
        .load_addr(load_addr),
        .resp_valid(resp_valid),
        .resp_addr(resp_addr),
        .resp_block(resp_block)
    );

endmodule

// ==== source/priority_select.sv ====
module priority_select #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt,
    output logic             any
);

    logic [WIDTH-1:0] taken; // a lower index already won.

    always_comb begin
        gnt = '0;
        taken = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (i > 0) begin
                taken[i] = taken[i-1] | req[i-1];
            end
            gnt[i] = req[i] & ~taken[i];
        end
    end

    assign any = |req;

endmodule

// ==== verif/load_unit_asserts.sv ====
module load_unit_asserts (
    input logic                               clock,
    input logic                               reset,
    input logic                               issue_en,
    input logic                               full,
    input logic                               store_en,
    input logic                               load_req,
    input logic [load_unit_pkg::LD_DEPTH-1:0] result_valid
);

    int failures = 0;

    // stores own the memory port.
    no_load_during_store: assert property (@(posedge clock) disable iff (reset)
        !(load_req && store_en))
        else begin
            $error("load request issued while a store was in progress");
            failures++;
        end

    no_result_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> (result_valid == '0))
        else begin
            $error("result valid in the first cycle after reset");
            failures++;
        end

    // full is seen by the issuer one cycle late.
    no_issue_when_full: assert property (@(posedge clock) disable iff (reset)
        issue_en |-> !$past(full))
        else begin
            $error("load issued while the buffer was full");
            failures++;
        end

endmodule

bind load_buffer load_unit_asserts load_unit_asserts_i (
    .clock(clock),
    .reset(reset),
    .issue_en(issue_en),
    .full(full),
    .store_en(store_en),
    .load_req(load_req),
    .result_valid(result_valid)
);

// ==== verif/load_unit_tb.sv ====
module load_unit_tb;
    import load_unit_pkg::*;

    localparam int TOTAL_LOADS = 69;
    localparam int CYCLE_LIMIT = 40 * TOTAL_LOADS;

    logic clock;
    logic reset;
    logic issue_en;
    logic [XLEN-1:0] issue_base;
    logic [XLEN-1:0] issue_offset;
    logic [2:0] issue_funct3;
    logic [TAG_W-1:0] issue_dest;
    logic [BR_W-1:0] issue_br_mask;
    logic [1:0] br_task;
    logic [BR_W-1:0] br_id;
    logic store_en;
    logic [XLEN-1:0] store_addr;
    mem_block_t store_data;
    logic [LD_DEPTH-1:0] cdb_stall;
    logic full;
    logic [LD_DEPTH-1:0] result_valid;
    logic [LD_DEPTH-1:0][TAG_W-1:0] result_dest;
    logic [LD_DEPTH-1:0][DATA_W-1:0] result_data;

    logic [63:0] model [MEM_BLOCKS];       // mirror of every store.
    logic [DATA_W-1:0] exp_data [2**TAG_W];
    logic [2**TAG_W-1:0] exp_pending;
    logic [31:0] lfsr = 32'hcf30;
    int pending_count = 0;
    int errors = 0;
    int cycles = 0;
    int req_count = 0;

    load_unit_top load_unit_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, results still outstanding", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [63:0] random_block();
        logic [63:0] b;
        logic bit_new;
        b = '0;
        for (int i = 0; i < 64; i++) begin
            bit_new = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32+x^22+x^2+x+1.
            lfsr = {lfsr[30:0], bit_new};
            b = {b[62:0], bit_new};
        end
        return b;
    endfunction

    // lane by shifting the whole double, then extend by funct3[2].
    function automatic logic [DATA_W-1:0] expected_value(input logic [XLEN-1:0] a,
                                                         input logic [2:0] f3);
        logic [63:0] raw;
        logic [63:0] lane_mask;
        int nbits;
        raw = model[a[BLOCK_OFS_W +: MEM_IDX_W]] >> (a[2:0] * 8);
        nbits = 8 << f3[1:0];
        if (nbits < 64) begin
            lane_mask = (64'd1 << nbits) - 64'd1;
            raw = raw & lane_mask;
            if (!f3[2] && raw[nbits-1]) begin
                raw = raw | ~lane_mask;
            end
        end
        return raw;
    endfunction

    task automatic compare_data(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_tag(input string name, input logic [TAG_W-1:0] got,
                               input logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_result(input logic [TAG_W-1:0] dest, input logic [DATA_W-1:0] value);
        exp_data[dest] = value;
        exp_pending[dest] = 1'b1;
        pending_count++;
    endtask

    // every slot offered without a stall is taken at the next edge.
    always @(negedge clock) begin
        if (!reset) begin
            if (load_unit_top_i.load_req) begin
                req_count++;
            end
            for (int s = 0; s < LD_DEPTH; s++) begin
                if (result_valid[s] && !cdb_stall[s]) begin
                    if (!exp_pending[result_dest[s]]) begin
                        $display("unexpected result for tag %0d on slot %0d", result_dest[s], s);
                        errors++;
                    end else begin
                        compare_data($sformatf("result_data[%0d]", s), result_data[s],
                                     exp_data[result_dest[s]]);
                        exp_pending[result_dest[s]] = 1'b0;
                        pending_count--;
                    end
                end
            end
        end
    end

    task automatic store_block(input int idx, input logic [63:0] blk);
        @(posedge clock);
        store_en <= 1'b1;
        store_addr <= idx * 8;
        store_data <= blk;
        model[idx] = blk;
        @(posedge clock);
        store_en <= 1'b0;
    endtask

    task automatic issue_load(input logic [XLEN-1:0] base, input logic [XLEN-1:0] offset,
                              input logic [2:0] f3, input logic [TAG_W-1:0] dest,
                              input logic [BR_W-1:0] br_mask, input bit survives);
        @(negedge clock);
        while (full) begin
            @(negedge clock);
        end
        @(posedge clock);
        issue_en <= 1'b1;
        issue_base <= base;
        issue_offset <= offset;
        issue_funct3 <= f3;
        issue_dest <= dest;
        issue_br_mask <= br_mask;
        if (survives) begin
            expect_result(dest, (dest == '0) ? '0 : expected_value(base + offset, f3));
        end
        @(posedge clock);
        issue_en <= 1'b0;
    endtask

    task automatic wait_done();
        while (pending_count != 0) begin
            @(posedge clock);
        end
    endtask

    task automatic test_sizes();
        logic [2:0] codes [7] = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2, 3'd6, 3'd3};
        int blocks [2] = '{3, 200};
        int n;
        n = 0;
        foreach (blocks[b]) begin
            store_block(blocks[b], random_block());
        end
        foreach (blocks[b]) begin
            for (int k = 0; k < 7; k++) begin
                for (int o = 0; o < 8; o += (1 << codes[k][1:0])) begin
                    // negative offset runs the address adder.
                    issue_load(blocks[b] * 8 + 64, o - 64, codes[k], 1 + (n % 31), '0, 1'b1);
                    wait_done();
                    n++;
                end
            end
        end
    endtask

    task automatic test_zero_dest();
        int reqs_before;
        reqs_before = req_count;
        issue_load(3 * 8, 0, 3'd3, '0, '0, 1'b1);
        wait_done();
        if (req_count != reqs_before) begin
            $display("ERR load_req count got %h expected %h", req_count, reqs_before);
            errors++;
        end
    endtask

    task automatic test_backpressure();
        logic [LD_DEPTH-1:0][DATA_W-1:0] held_data;
        logic [LD_DEPTH-1:0][TAG_W-1:0] held_dest;
        @(posedge clock);
        cdb_stall <= '1;
        for (int i = 0; i < LD_DEPTH; i++) begin
            issue_load(200 * 8, i * 2, 3'd1, 40 + i, '0, 1'b1);
        end
        @(negedge clock);
        while (result_valid != '1) begin
            @(negedge clock);
        end
        if (!full) begin
            $display("full stayed low with every entry holding a result");
            errors++;
        end
        held_data = result_data;
        held_dest = result_dest;
        repeat (5) @(negedge clock);
        for (int s = 0; s < LD_DEPTH; s++) begin
            // lowest free entry first, so slot s holds the s-th load.
            compare_tag($sformatf("result_dest[%0d]", s), held_dest[s], 40 + s);
            compare_data($sformatf("held result_data[%0d]", s), result_data[s], held_data[s]);
            compare_tag($sformatf("held result_dest[%0d]", s), result_dest[s], held_dest[s]);
        end
        for (int s = 0; s < LD_DEPTH; s++) begin
            @(posedge clock);
            cdb_stall[s] <= 1'b0;
            while (exp_pending[held_dest[s]]) begin
                @(posedge clock);
            end
        end
        @(negedge clock);
        if (full) begin
            $display("full still high after every result drained");
            errors++;
        end
    endtask

    task automatic test_branches();
        issue_load(3 * 8, 4, 3'd2, 21, 4'b0010, 1'b1);
        br_task <= BR_CLEAR; // entry allocated at this edge.
        br_id <= 4'b0010;
        @(posedge clock);
        br_task <= BR_NONE;
        issue_load(3 * 8, 0, 3'd3, 20, 4'b0001, 1'b0);
        br_task <= BR_SQUASH; // cleared bit must not kill tag 21.
        br_id <= 4'b0011;
        @(posedge clock);
        br_task <= BR_NONE;
        br_id <= '0;
        issue_load(200 * 8, 0, 3'd3, 22, 4'b0100, 1'b0);
        @(posedge clock);
        br_task <= BR_SQUASH; // read already in flight.
        br_id <= 4'b0100;
        @(posedge clock);
        br_task <= BR_NONE;
        br_id <= '0;
        wait_done();
        repeat (20) @(posedge clock);
    endtask

    task automatic test_store_contention();
        logic [63:0] blk;
        for (int c = 0; c < 6; c++) begin
            @(posedge clock);
            blk = random_block();
            store_en <= 1'b1;
            store_addr <= (10 + c) * 8;
            store_data <= blk;
            model[10 + c] = blk;
            if (c % 2 == 1) begin
                issue_en <= 1'b1;
                issue_base <= (10 + c - 1) * 8;
                issue_offset <= 0;
                issue_funct3 <= 3'd3;
                issue_dest <= 50 + c;
                issue_br_mask <= '0;
                expect_result(50 + c, expected_value((10 + c - 1) * 8, 3'd3));
            end else begin
                issue_en <= 1'b0;
            end
        end
        @(posedge clock);
        store_en <= 1'b0;
        issue_en <= 1'b0;
        wait_done();
    endtask

    initial begin
        int assert_failures;
        reset = 1'b1;
        issue_en = 1'b0;
        issue_base = '0;
        issue_offset = '0;
        issue_funct3 = '0;
        issue_dest = '0;
        issue_br_mask = '0;
        br_task = BR_NONE;
        br_id = '0;
        store_en = 1'b0;
        store_addr = '0;
        store_data = '0;
        cdb_stall = '0;
        exp_pending = '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        test_sizes();
        test_zero_dest();
        test_backpressure();
        test_branches();
        test_store_contention();
        repeat (5) @(posedge clock);
        assert_failures = load_unit_top_i.load_buffer_i.load_unit_asserts_i.failures;
        $display("errors: %0d, assertion failures: %0d", errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
